/* hw/fp_adc_capture.sv */
`timescale 1ns/100ps

`include "fp_consts.svh"

module fp_adc_capture (
	input	logic					clk50_in,
	input	logic					reset,
	input	logic					sys_reset_pulse,
	input	logic [`FP_N_ADC-1:0]	adc_data_valid,
	input	fp_pkg::adc_sample_t	adc_data_a,
	input	fp_pkg::adc_sample_t	adc_data_b,
	output	fp_pkg::adc_sample_t	samples [`FP_N_ADC]
);

	import fp_pkg::*;

	localparam int N_HALF = `FP_N_ADC / 2;

	logic clear;

	assign clear = reset | sys_reset_pulse;

	////////////////////////////////////////////////////////////
	// per channel holding registers
	////////////////////////////////////////////////////////////

	// lower half on bus a, upper half on bus b
	// each channel loads on its own valid bit, no priority
	for (genvar ch = 0; ch < `FP_N_ADC; ch++) begin : g_chan
		adc_sample_t bus_word;

		assign bus_word = (ch < N_HALF) ? adc_data_a : adc_data_b;

		always_ff @(posedge clk50_in) begin
			if (clear)
				samples[ch] <= '0;
			else if (adc_data_valid[ch])
				samples[ch] <= bus_word;	// latest sample
		end
	end

endmodule

/* hw/fp_consts.svh */
`ifndef FP_CONSTS_SVH
`define FP_CONSTS_SVH

////////////////////////////////////////////////////////////
// channel counts and widths
////////////////////////////////////////////////////////////

`define FP_N_ADC			6		// adc channels
`define FP_W_ADC			18		// adc sample width
`define FP_N_OUT			8		// output channels
`define FP_W_WORD			16		// host bus word
`define FP_W_ADC_OS			3		// adc oversample select
`define FP_W_OSF_OSM		6		// oversample ratio
`define FP_W_RTR_SEL		4		// router source / dest select
`define FP_W_OPP			48		// three host words
`define FP_PIPE_DEPTH_LOG2	4		// 16 entry pipe fifo

////////////////////////////////////////////////////////////
// endpoint addresses
////////////////////////////////////////////////////////////

// wire-ins
`define FP_EP_ADC_OS			8'h01
`define FP_EP_OSF_CD			8'h02
`define FP_EP_OSF_OSM			8'h03
`define FP_EP_PID_SETPOINT		8'h04
`define FP_EP_PID_P				8'h05
`define FP_EP_PID_I				8'h06
`define FP_EP_PID_D				8'h07
`define FP_EP_RTR_SRC			8'h09
`define FP_EP_RTR_DEST			8'h0A
`define FP_EP_OPP_INIT0			8'h0B	// low word, two more follow
`define FP_EP_OPP_MIN0			8'h0E
`define FP_EP_OPP_MAX0			8'h11
`define FP_EP_OSF_ACTIVE		8'h15
`define FP_EP_RTR_ACTIVE		8'h16
`define FP_EP_PID_LOCK			8'h17

// wire-outs
`define FP_EP_ADC_OUT0			8'h20	// channel 0, one address per channel
`define FP_EP_STATUS			8'h26

// trigger-ins
`define FP_EP_TRIG_CSTART		8'h53
`define FP_EP_TRIG_PID_CLEAR	8'h55
`define FP_EP_TRIG_DAC_REF		8'h56
`define FP_EP_TRIG_UPDATE		8'h57
`define FP_EP_TRIG_RESET		8'h58

// pipe-out
`define FP_EP_PIPE				8'hA3

`endif

/* hw/fp_endpoint_regs.sv */
`timescale 1ns/100ps

`include "fp_consts.svh"

module fp_endpoint_regs (
	input	logic				clk50_in,
	input	logic				reset,
	input	fp_pkg::host_req_t	req,
	output	fp_pkg::fp_config_t	cfg,
	output	fp_pkg::fp_trig_t	trig,
	output	logic				sys_reset_pulse
);

	import fp_pkg::*;

	fp_trig_t trig_next;

	////////////////////////////////////////////////////////////
	// wire-in registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk50_in) begin
		if (reset) begin
			cfg <= '0;
		end else if (req.wr) begin
			case (req.addr)
				`FP_EP_ADC_OS:				cfg.adc_os <= req.data[`FP_W_ADC_OS-1:0];
				`FP_EP_OSF_CD:				cfg.osf_cycle_delay <= req.data;
				`FP_EP_OSF_OSM:				cfg.osf_osm <= req.data[`FP_W_OSF_OSM-1:0];
				`FP_EP_PID_SETPOINT:		cfg.pid_setpoint <= req.data;
				`FP_EP_PID_P:				cfg.pid_p_coef <= req.data;
				`FP_EP_PID_I:				cfg.pid_i_coef <= req.data;
				`FP_EP_PID_D:				cfg.pid_d_coef <= req.data;
				`FP_EP_RTR_SRC:				cfg.rtr_src_sel <= req.data[`FP_W_RTR_SEL-1:0];
				`FP_EP_RTR_DEST:			cfg.rtr_dest_sel <= req.data[`FP_W_RTR_SEL-1:0];
				// 48 bit words, lowest word at lowest address
				`FP_EP_OPP_INIT0:			cfg.opp_init[15:0] <= req.data;
				`FP_EP_OPP_INIT0 + 8'd1:	cfg.opp_init[31:16] <= req.data;
				`FP_EP_OPP_INIT0 + 8'd2:	cfg.opp_init[47:32] <= req.data;
				`FP_EP_OPP_MIN0:			cfg.opp_min[15:0] <= req.data;
				`FP_EP_OPP_MIN0 + 8'd1:		cfg.opp_min[31:16] <= req.data;
				`FP_EP_OPP_MIN0 + 8'd2:		cfg.opp_min[47:32] <= req.data;
				`FP_EP_OPP_MAX0:			cfg.opp_max[15:0] <= req.data;
				`FP_EP_OPP_MAX0 + 8'd1:		cfg.opp_max[31:16] <= req.data;
				`FP_EP_OPP_MAX0 + 8'd2:		cfg.opp_max[47:32] <= req.data;
				`FP_EP_OSF_ACTIVE:			cfg.osf_activate <= req.data[`FP_N_ADC-1:0];
				`FP_EP_RTR_ACTIVE:			cfg.rtr_output_active <= req.data[`FP_N_OUT-1:0];
				`FP_EP_PID_LOCK:			cfg.pid_lock_en <= req.data[`FP_N_ADC-1:0];
				default: ;		// triggers and unmapped
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// trigger-ins
	////////////////////////////////////////////////////////////

	// pulses only on the write cycle, zero otherwise
	always_comb begin
		trig_next = '0;
		if (req.wr) begin
			case (req.addr)
				`FP_EP_TRIG_CSTART:		trig_next.adc_cstart = req.data[0];
				`FP_EP_TRIG_PID_CLEAR:	trig_next.pid_clear = req.data[`FP_N_ADC-1:0];
				`FP_EP_TRIG_DAC_REF:	trig_next.dac_ref_set = req.data[0];
				`FP_EP_TRIG_UPDATE:		trig_next.module_update = req.data[0];
				`FP_EP_TRIG_RESET:		trig_next.sys_reset = req.data[0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk50_in) begin
		if (reset)
			trig <= '0;
		else
			trig <= trig_next;		// registered, lasts one cycle
	end

	// internal copy for capture and fifo clearing
	assign sys_reset_pulse = trig.sys_reset;

endmodule

/* hw/fp_host_readback.sv */
`timescale 1ns/100ps

`include "fp_consts.svh"

module fp_host_readback (
	input	logic							clk50_in,
	input	logic							reset,
	input	fp_pkg::host_req_t				req,
	input	fp_pkg::adc_sample_t			samples [`FP_N_ADC],
	input	logic [15:0]					fifo_dout,
	input	logic							fifo_empty,
	input	logic [`FP_PIPE_DEPTH_LOG2:0]	fifo_count,
	input	logic							fifo_overflow,
	output	logic							pipe_pop,
	output	fp_pkg::host_rsp_t				rsp
);

	import fp_pkg::*;

	host_rsp_t		rsp_next;
	logic [15:0]	status_word;
	logic			pipe_rd;

	assign pipe_rd	= req.rd && (req.addr == `FP_EP_PIPE);
	assign pipe_pop	= pipe_rd & ~fifo_empty;	// same cycle as the read

	// overflow, empty, then fifo count from bit 8
	always_comb begin
		status_word = '0;
		status_word[0] = fifo_overflow;
		status_word[1] = fifo_empty;
		status_word[8 +: `FP_PIPE_DEPTH_LOG2+1] = fifo_count;
	end

	////////////////////////////////////////////////////////////
	// read decode
	////////////////////////////////////////////////////////////

	always_comb begin
		rsp_next = '0;
		rsp_next.valid = req.rd;
		if (req.rd) begin
			// wire-outs, top 16 bits of each sample
			for (int ch = 0; ch < `FP_N_ADC; ch++) begin
				if (req.addr == `FP_EP_ADC_OUT0 + ch)
					rsp_next.data = samples[ch][`FP_W_ADC-1 -: 16];
			end
			if (req.addr == `FP_EP_STATUS)
				rsp_next.data = status_word;
			if (pipe_rd && !fifo_empty)
				rsp_next.data = fifo_dout;		// empty pipe reads zero
		end
	end

	always_ff @(posedge clk50_in) begin
		if (reset)
			rsp <= '0;
		else
			rsp <= rsp_next;	// one cycle after the strobe
	end

endmodule

/* hw/fp_pipe_fifo.sv */
`timescale 1ns/100ps

`include "fp_consts.svh"

module fp_pipe_fifo #(
	parameter int DEPTH_LOG2 = `FP_PIPE_DEPTH_LOG2
) (
	input	logic					clk50_in,
	input	logic					reset,
	input	logic					sys_reset_pulse,
	input	logic					push,
	input	logic [15:0]			din,
	input	logic					pop,
	output	logic [15:0]			dout,
	output	logic					empty,
	output	logic [DEPTH_LOG2:0]	count,
	output	logic					overflow
);

	localparam int DEPTH = 2 ** DEPTH_LOG2;

	logic [15:0]			mem [DEPTH];
	logic [DEPTH_LOG2-1:0]	wr_ptr;
	logic [DEPTH_LOG2-1:0]	rd_ptr;
	logic					full;
	logic					push_ok;
	logic					pop_ok;
	logic					clear;

	assign clear	= reset | sys_reset_pulse;
	assign full		= (count == DEPTH[DEPTH_LOG2:0]);
	assign empty	= (count == '0);
	assign push_ok	= push & ~full;		// full push is dropped
	assign pop_ok	= pop & ~empty;		// empty pop ignored

	////////////////////////////////////////////////////////////
	// storage and pointers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk50_in) begin
		if (push_ok)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk50_in) begin
		if (clear) begin
			wr_ptr		<= '0;
			rd_ptr		<= '0;
			count		<= '0;
			overflow	<= 1'b0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;	// wraps at depth
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			if (push_ok && !pop_ok)
				count <= count + 1'b1;
			else if (pop_ok && !push_ok)
				count <= count - 1'b1;
			// sticky until reset or sys_reset trigger
			if (push && full)
				overflow <= 1'b1;
		end
	end

	// first word fall through
	assign dout = mem[rd_ptr];

endmodule

/* hw/fp_pkg.sv */
`include "fp_consts.svh"

package fp_pkg;

	////////////////////////////////////////////////////////////
	// host bus
	////////////////////////////////////////////////////////////

	// one host bus cycle, wr and rd never together
	typedef struct packed {
		logic					wr;		// write strobe
		logic					rd;		// read strobe
		logic [7:0]				addr;
		logic [`FP_W_WORD-1:0]	data;
	} host_req_t;

	typedef struct packed {
		logic					valid;
		logic [`FP_W_WORD-1:0]	data;
	} host_rsp_t;

	////////////////////////////////////////////////////////////
	// configuration and triggers
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [`FP_W_ADC_OS-1:0]	adc_os;
		logic [`FP_N_ADC-1:0]		osf_activate;
		logic [`FP_W_WORD-1:0]		osf_cycle_delay;
		logic [`FP_W_OSF_OSM-1:0]	osf_osm;
		logic [`FP_N_ADC-1:0]		pid_lock_en;
		logic [`FP_W_WORD-1:0]		pid_setpoint;
		logic signed [15:0]			pid_p_coef;
		logic signed [15:0]			pid_i_coef;
		logic signed [15:0]			pid_d_coef;
		logic [`FP_W_RTR_SEL-1:0]	rtr_src_sel;
		logic [`FP_W_RTR_SEL-1:0]	rtr_dest_sel;
		logic [`FP_N_OUT-1:0]		rtr_output_active;
		logic [`FP_W_OPP-1:0]		opp_init;
		logic [`FP_W_OPP-1:0]		opp_min;
		logic [`FP_W_OPP-1:0]		opp_max;
	} fp_config_t;

	// single cycle pulses
	typedef struct packed {
		logic						adc_cstart;
		logic [`FP_N_ADC-1:0]		pid_clear;	// one per channel
		logic						dac_ref_set;
		logic						module_update;
		logic						sys_reset;
	} fp_trig_t;

	typedef logic [`FP_W_ADC-1:0] adc_sample_t;

endpackage

/* hw/frontpanel_interface.sv */
`timescale 1ns/100ps

`include "fp_consts.svh"

module frontpanel_interface (
	input	logic					clk50_in,
	input	logic					reset,
	input	fp_pkg::host_req_t		req,
	output	fp_pkg::host_rsp_t		rsp,
	input	logic [`FP_N_ADC-1:0]	adc_data_valid,
	input	fp_pkg::adc_sample_t	adc_data_a,
	input	fp_pkg::adc_sample_t	adc_data_b,
	output	fp_pkg::fp_config_t		cfg,
	output	fp_pkg::fp_trig_t		trig
);

	import fp_pkg::*;

	adc_sample_t					samples [`FP_N_ADC];
	logic							sys_reset_pulse;
	logic [15:0]					pipe_din;
	logic [15:0]					fifo_dout;
	logic							fifo_empty;
	logic [`FP_PIPE_DEPTH_LOG2:0]	fifo_count;
	logic							fifo_overflow;
	logic							pipe_pop;

	assign pipe_din = adc_data_a[`FP_W_ADC-1 -: 16];	// channel 0 bits 17:2

	////////////////////////////////////////////////////////////
	// host writes
	////////////////////////////////////////////////////////////

	fp_endpoint_regs u_endpoint_regs (
		.clk50_in			(clk50_in),
		.reset				(reset),
		.req				(req),
		.cfg				(cfg),
		.trig				(trig),
		.sys_reset_pulse	(sys_reset_pulse)
	);

	////////////////////////////////////////////////////////////
	// adc side
	////////////////////////////////////////////////////////////

	fp_adc_capture u_adc_capture (
		.clk50_in			(clk50_in),
		.reset				(reset),
		.sys_reset_pulse	(sys_reset_pulse),
		.adc_data_valid		(adc_data_valid),
		.adc_data_a			(adc_data_a),
		.adc_data_b			(adc_data_b),
		.samples			(samples)
	);

	fp_pipe_fifo #(
		.DEPTH_LOG2			(`FP_PIPE_DEPTH_LOG2)
	) u_pipe_fifo (
		.clk50_in			(clk50_in),
		.reset				(reset),
		.sys_reset_pulse	(sys_reset_pulse),
		.push				(adc_data_valid[0]),
		.din				(pipe_din),
		.pop				(pipe_pop),
		.dout				(fifo_dout),
		.empty				(fifo_empty),
		.count				(fifo_count),
		.overflow			(fifo_overflow)
	);

	// host reads
	fp_host_readback u_host_readback (
		.clk50_in			(clk50_in),
		.reset				(reset),
		.req				(req),
		.samples			(samples),
		.fifo_dout			(fifo_dout),
		.fifo_empty			(fifo_empty),
		.fifo_count			(fifo_count),
		.fifo_overflow		(fifo_overflow),
		.pipe_pop			(pipe_pop),
		.rsp				(rsp)
	);

endmodule

/* tb.f */
+incdir+hw
hw/fp_pkg.sv
hw/fp_endpoint_regs.sv
hw/fp_adc_capture.sv
hw/fp_pipe_fifo.sv
hw/fp_host_readback.sv
hw/frontpanel_interface.sv
tb/frontpanel_interface_asserts.sv
tb/frontpanel_interface_tb.sv

/* tb/frontpanel_interface_asserts.sv */
`timescale 1ns/100ps

module frontpanel_interface_asserts (
	input	logic					clk50_in,
	input	logic					reset,
	input	fp_pkg::host_req_t		req,
	input	fp_pkg::host_rsp_t		rsp,
	input	fp_pkg::fp_config_t		cfg,
	input	fp_pkg::fp_trig_t		trig
);

	int fail_count = 0;		// failed assertions so far

	////////////////////////////////////////////////////////////
	// host read response
	////////////////////////////////////////////////////////////

	a_rsp_after_rd : assert property (
		@(posedge clk50_in) disable iff (reset) rsp.valid == $past(req.rd)
	) else begin
		$error("rsp.valid is not the read strobe of the previous cycle");
		fail_count++;
	end

	////////////////////////////////////////////////////////////
	// trigger pulses
	////////////////////////////////////////////////////////////

	a_trig_one_cycle : assert property (
		@(posedge clk50_in) disable iff (reset) (trig != '0) |=> (trig == '0)
	) else begin
		$error("trigger pulse held longer than one cycle");
		fail_count++;
	end

	// pulses only come from a host write
	a_trig_from_write : assert property (
		@(posedge clk50_in) disable iff (reset) (trig != '0) |-> $past(req.wr)
	) else begin
		$error("trigger pulse without a host write");
		fail_count++;
	end

	a_reset_quiet : assert property (
		@(posedge clk50_in) reset |=> (trig == '0 && !rsp.valid && cfg == '0)
	) else begin
		$error("output active during reset");
		fail_count++;
	end

endmodule

bind frontpanel_interface frontpanel_interface_asserts u_asserts (
	.clk50_in	(clk50_in),
	.reset		(reset),
	.req		(req),
	.rsp		(rsp),
	.cfg		(cfg),
	.trig		(trig)
);

/* tb/frontpanel_interface_tb.sv */
`timescale 1ns/100ps

`include "fp_consts.svh"

module frontpanel_interface_tb;

	import fp_pkg::*;

	typedef logic [`FP_N_ADC-1:0] valid_t;

	localparam int PIPE_DEPTH	= 1 << `FP_PIPE_DEPTH_LOG2;
	localparam int N_WIRE		= 21;
	localparam int N_TRIG		= 5;
	localparam int WIRE_PASSES	= 2;
	localparam int TRIG_REPS	= 3;
	localparam int ADC_CYCLES	= 60;
	localparam int PIPE_FILL	= 10;
	// bus cycles per test, summed for the watchdog
	localparam int N_OPS = (WIRE_PASSES * N_WIRE + 2) + (TRIG_REPS * N_TRIG * 2)
		+ (ADC_CYCLES + `FP_N_ADC + 1)
		+ (3 + 2 * PIPE_FILL + 1 + 1 + PIPE_DEPTH + 4 + 1 + PIPE_DEPTH + 1 + 1)
		+ (7 + 4 + 1);
	localparam int TIMEOUT_CYCLES = N_OPS * 4 + 100;

	logic					clk50_in;
	logic					reset;
	host_req_t				req;
	host_rsp_t				rsp;
	valid_t					adc_data_valid;
	adc_sample_t			adc_data_a;
	adc_sample_t			adc_data_b;
	fp_config_t				cfg;
	fp_trig_t				trig;

	// reference model state
	fp_config_t				exp_cfg;
	fp_trig_t				exp_trig;
	host_rsp_t				exp_rsp;
	adc_sample_t			model_samples [`FP_N_ADC];
	logic [15:0]			model_fifo [$];
	logic					model_ovf;
	logic					pending_sysrst;		// sys_reset pulse in the next cycle
	logic					compare_en;
	logic [15:0]			lfsr_state;

	logic [7:0] wire_addrs [N_WIRE] = '{
		`FP_EP_ADC_OS, `FP_EP_OSF_CD, `FP_EP_OSF_OSM, `FP_EP_PID_SETPOINT,
		`FP_EP_PID_P, `FP_EP_PID_I, `FP_EP_PID_D, `FP_EP_RTR_SRC, `FP_EP_RTR_DEST,
		`FP_EP_OPP_INIT0, `FP_EP_OPP_INIT0 + 8'd1, `FP_EP_OPP_INIT0 + 8'd2,
		`FP_EP_OPP_MIN0, `FP_EP_OPP_MIN0 + 8'd1, `FP_EP_OPP_MIN0 + 8'd2,
		`FP_EP_OPP_MAX0, `FP_EP_OPP_MAX0 + 8'd1, `FP_EP_OPP_MAX0 + 8'd2,
		`FP_EP_OSF_ACTIVE, `FP_EP_RTR_ACTIVE, `FP_EP_PID_LOCK
	};
	logic [7:0] trig_addrs [N_TRIG] = '{
		`FP_EP_TRIG_CSTART, `FP_EP_TRIG_PID_CLEAR, `FP_EP_TRIG_DAC_REF,
		`FP_EP_TRIG_UPDATE, `FP_EP_TRIG_RESET
	};

	frontpanel_interface DUT (
		.clk50_in		(clk50_in),
		.reset			(reset),
		.req			(req),
		.rsp			(rsp),
		.adc_data_valid	(adc_data_valid),
		.adc_data_a		(adc_data_a),
		.adc_data_b		(adc_data_b),
		.cfg			(cfg),
		.trig			(trig)
	);

	initial begin
		clk50_in = 1'b0;
		forever #10 clk50_in = ~clk50_in;
	end

	////////////////////////////////////////////////////////////
	// random bits and reference functions
	////////////////////////////////////////////////////////////

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	function automatic fp_config_t next_config(input fp_config_t c, input host_req_t r);
		int w;
		if (r.wr) begin
			case (r.addr)
				`FP_EP_ADC_OS:			c.adc_os = r.data[`FP_W_ADC_OS-1:0];
				`FP_EP_OSF_CD:			c.osf_cycle_delay = r.data;
				`FP_EP_OSF_OSM:			c.osf_osm = r.data[`FP_W_OSF_OSM-1:0];
				`FP_EP_PID_SETPOINT:	c.pid_setpoint = r.data;
				`FP_EP_PID_P:			c.pid_p_coef = r.data;
				`FP_EP_PID_I:			c.pid_i_coef = r.data;
				`FP_EP_PID_D:			c.pid_d_coef = r.data;
				`FP_EP_RTR_SRC:			c.rtr_src_sel = r.data[`FP_W_RTR_SEL-1:0];
				`FP_EP_RTR_DEST:		c.rtr_dest_sel = r.data[`FP_W_RTR_SEL-1:0];
				`FP_EP_OSF_ACTIVE:		c.osf_activate = r.data[`FP_N_ADC-1:0];
				`FP_EP_RTR_ACTIVE:		c.rtr_output_active = r.data[`FP_N_OUT-1:0];
				`FP_EP_PID_LOCK:		c.pid_lock_en = r.data[`FP_N_ADC-1:0];
				default: ;
			endcase
			// word w of a 48 bit field sits at base + w
			w = int'(r.addr) - int'(`FP_EP_OPP_INIT0);
			if (w >= 0 && w < 3)
				c.opp_init[16*w +: 16] = r.data;
			w = int'(r.addr) - int'(`FP_EP_OPP_MIN0);
			if (w >= 0 && w < 3)
				c.opp_min[16*w +: 16] = r.data;
			w = int'(r.addr) - int'(`FP_EP_OPP_MAX0);
			if (w >= 0 && w < 3)
				c.opp_max[16*w +: 16] = r.data;
		end
		return c;
	endfunction

	function automatic fp_trig_t trig_pulses(input host_req_t r);
		fp_trig_t t;
		t = '0;
		if (r.wr) begin
			if (r.addr == `FP_EP_TRIG_CSTART)
				t.adc_cstart = r.data[0];
			if (r.addr == `FP_EP_TRIG_PID_CLEAR)
				t.pid_clear = r.data[`FP_N_ADC-1:0];
			if (r.addr == `FP_EP_TRIG_DAC_REF)
				t.dac_ref_set = r.data[0];
			if (r.addr == `FP_EP_TRIG_UPDATE)
				t.module_update = r.data[0];
			if (r.addr == `FP_EP_TRIG_RESET)
				t.sys_reset = r.data[0];
		end
		return t;
	endfunction

	// response from the model state before the edge
	function automatic host_rsp_t read_response(input host_req_t r);
		host_rsp_t e;
		int ch;
		e = '0;
		e.valid = r.rd;
		ch = int'(r.addr) - int'(`FP_EP_ADC_OUT0);
		if (r.rd) begin
			if (ch >= 0 && ch < `FP_N_ADC) begin
				e.data = model_samples[ch][`FP_W_ADC-1:2];
			end else if (r.addr == `FP_EP_STATUS) begin
				e.data = 16'(model_fifo.size()) << 8;
				e.data[1] = (model_fifo.size() == 0);
				e.data[0] = model_ovf;
			end else if (r.addr == `FP_EP_PIPE && model_fifo.size() != 0) begin
				e.data = model_fifo[0];
			end
		end
		return e;
	endfunction

	////////////////////////////////////////////////////////////
	// bus cycles
	////////////////////////////////////////////////////////////

	task automatic bus_cycle(input host_req_t r, input valid_t valid,
			input adc_sample_t a, input adc_sample_t b);
		int old_size;
		@(negedge clk50_in);
		req = r;
		adc_data_valid = valid;
		adc_data_a = a;
		adc_data_b = b;
		exp_rsp = read_response(r);
		old_size = model_fifo.size();
		if (pending_sysrst) begin
			foreach (model_samples[ch])
				model_samples[ch] = '0;
			model_fifo.delete();
			model_ovf = 1'b0;
		end else begin
			if (r.rd && r.addr == `FP_EP_PIPE && old_size != 0)
				void'(model_fifo.pop_front());
			foreach (model_samples[ch])
				if (valid[ch])
					model_samples[ch] = (ch < `FP_N_ADC / 2) ? a : b;
			if (valid[0]) begin
				if (old_size < PIPE_DEPTH)
					model_fifo.push_back(a[`FP_W_ADC-1:2]);
				else
					model_ovf = 1'b1;	// full, sample dropped
			end
		end
		exp_cfg = next_config(exp_cfg, r);
		exp_trig = trig_pulses(r);
		pending_sysrst = exp_trig.sys_reset;
	endtask

	task automatic write_word(input logic [7:0] addr, input logic [15:0] data);
		host_req_t r;
		r = '0;
		r.wr = 1'b1;
		r.addr = addr;
		r.data = data;
		bus_cycle(r, '0, '0, '0);
	endtask

	task automatic read_word(input logic [7:0] addr);
		host_req_t r;
		r = '0;
		r.rd = 1'b1;
		r.addr = addr;
		bus_cycle(r, '0, '0, '0);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) bus_cycle('0, '0, '0, '0);
	endtask

	task automatic push_sample(input adc_sample_t a);
		bus_cycle('0, valid_t'(1), a, '0);
	endtask

	////////////////////////////////////////////////////////////
	// compare
	////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_config(input fp_config_t got, input fp_config_t exp);
		if (got !== exp) begin
			$display("error: cfg got %h expected %h", got, exp);
			abort_run();
		end
	endtask

	task automatic check_trig(input fp_trig_t got, input fp_trig_t exp);
		if (got !== exp) begin
			$display("error: trig got %h expected %h", got, exp);
			abort_run();
		end
	endtask

	task automatic check_rsp(input host_rsp_t got, input host_rsp_t exp);
		if (got.valid !== exp.valid) begin
			$display("error: rsp.valid got %h expected %h", got.valid, exp.valid);
			abort_run();
		end else if (exp.valid && got.data !== exp.data) begin
			$display("error: rsp.data got %h expected %h", got.data, exp.data);
			abort_run();
		end
	endtask

	initial begin : compare
		forever begin
			@(posedge clk50_in);
			#5;		// mid high phase
			if (compare_en) begin
				check_config(cfg, exp_cfg);
				check_trig(trig, exp_trig);
				check_rsp(rsp, exp_rsp);
			end
			if (DUT.u_asserts.fail_count != 0) begin
				$display("a bound assertion failed");
				abort_run();
			end
		end
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk50_in);
		$display("timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		abort_run();
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	initial begin : stimulus
		host_req_t r;
		lfsr_state = 16'd27;
		compare_en = 1'b0;
		reset = 1'b1;
		req = '0;
		adc_data_valid = '0;
		adc_data_a = '0;
		adc_data_b = '0;
		exp_cfg = '0;
		exp_trig = '0;
		exp_rsp = '0;
		model_ovf = 1'b0;
		pending_sysrst = 1'b0;
		model_fifo.delete();
		foreach (model_samples[ch])
			model_samples[ch] = '0;
		repeat (2) @(posedge clk50_in);
		@(negedge clk50_in);
		reset = 1'b0;
		compare_en = 1'b1;

		// wire-ins, then unmapped writes
		for (int p = 0; p < WIRE_PASSES; p++)
			foreach (wire_addrs[i])
				write_word(wire_addrs[i], 16'(rand_bits(16)));
		write_word(8'h08, 16'hFFFF);
		write_word(8'h30, 16'hFFFF);

		for (int n = 0; n < TRIG_REPS; n++)
			foreach (trig_addrs[i]) begin
				write_word(trig_addrs[i], 16'(rand_bits(16)));
				idle_cycles(1);
			end

		// random capture with wire-out reads
		for (int n = 0; n < ADC_CYCLES; n++) begin
			r = '0;
			r.rd = 1'b1;
			r.addr = `FP_EP_ADC_OUT0 + 8'(rand_bits(8) % `FP_N_ADC);
			bus_cycle(r, valid_t'(rand_bits(`FP_N_ADC)),
				adc_sample_t'(rand_bits(`FP_W_ADC)), adc_sample_t'(rand_bits(`FP_W_ADC)));
		end
		for (int ch = 0; ch < `FP_N_ADC; ch++)
			read_word(`FP_EP_ADC_OUT0 + 8'(ch));
		read_word(`FP_EP_STATUS);

		// pipe order, empty reads and overflow
		write_word(`FP_EP_TRIG_RESET, 16'h0001);
		idle_cycles(1);
		read_word(`FP_EP_PIPE);
		for (int n = 0; n < PIPE_FILL; n++)
			push_sample(adc_sample_t'(rand_bits(`FP_W_ADC)));
		for (int n = 0; n <= PIPE_FILL; n++)
			read_word(`FP_EP_PIPE);
		read_word(`FP_EP_STATUS);
		for (int n = 0; n < PIPE_DEPTH + 4; n++)
			push_sample(adc_sample_t'(rand_bits(`FP_W_ADC)));
		read_word(`FP_EP_STATUS);
		for (int n = 0; n <= PIPE_DEPTH; n++)
			read_word(`FP_EP_PIPE);
		read_word(`FP_EP_STATUS);

		// sys_reset clears samples and fifo, keeps config
		for (int n = 0; n < 5; n++)
			bus_cycle('0, valid_t'(6'b001001), adc_sample_t'(rand_bits(`FP_W_ADC)),
				adc_sample_t'(rand_bits(`FP_W_ADC)));
		write_word(`FP_EP_TRIG_RESET, 16'h0001);
		idle_cycles(1);
		read_word(`FP_EP_STATUS);
		read_word(`FP_EP_ADC_OUT0);
		read_word(`FP_EP_ADC_OUT0 + 8'd3);
		read_word(`FP_EP_PIPE);
		idle_cycles(1);

		repeat (2) @(negedge clk50_in);
		if (DUT.u_asserts.fail_count == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("a bound assertion failed");
			abort_run();
		end
	end

endmodule
